// File: common/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// word address width of the core
`define BP_ADDR_W 30

// index width shared by all direct-mapped tables
`define BP_IDX_W 8

`define BP_GH_W 8

// return address stack entries
`define BP_RAS_DEPTH 8

`define BP_TAG_W 8

`define BP_RESET_PC 30'h0700_0000 // first fetch address

`endif

// File: common/bp_meta_pkg.sv
`default_nettype none

`include "bp_consts.svh"

package bp_meta_pkg;

    // saturating counter where msb set means taken or gshare preferred
    typedef logic [1:0] ctr2_t;

    typedef struct packed {
        logic                  valid;
        logic [`BP_TAG_W-1:0]  tag;
        logic [`BP_ADDR_W-1:0] target;
    } btb_entry_t;

    // travels with each prediction and comes back from execute
    typedef struct packed {
        ctr2_t                bim_ctr;
        ctr2_t                gsh_ctr;
        ctr2_t                cho_ctr;
        logic [`BP_GH_W-1:0]  gh;      // history used for the gshare index
        logic                 taken;   // predicted direction
    } bp_meta_t;

endpackage

`default_nettype wire

// File: common/bp_branch_pkg.sv
`default_nettype none

`include "bp_consts.svh"

package bp_branch_pkg;

    import bp_meta_pkg::*;

    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1, // conditional
        ret           = 3'd4,
        indirect_jump = 3'd5,
        call          = 3'd6,
        jump          = 3'd7
    } bp_kind_t;

    // what execute reports for one branch
    typedef struct packed {
        logic [`BP_ADDR_W-1:0] pc;
        bp_kind_t              kind;
        logic                  taken;
        logic [`BP_ADDR_W-1:0] npc;
        logic [`BP_ADDR_W-1:0] ret_pc;
        bp_meta_t              meta;
    } bp_resolved_t;

endpackage

`default_nettype wire

// File: common/bp_update_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bp_update_if
    import bp_branch_pkg::*;
();

    logic         valid; // update_en
    bp_resolved_t ex;

    modport src (
        output valid,
        output ex
    );

    modport dir (
        input valid,
        input ex
    );

    modport hist (
        input valid,
        input ex
    );

    modport tgt (
        input valid,
        input ex
    );

endinterface

`default_nettype wire

// File: design/pred_table.sv
`timescale 1ns/1ps
`default_nettype none

module pred_table #(
    parameter int     IDX_W     = 8,
    parameter type    entry_t   = logic,
    parameter entry_t RESET_VAL = '0
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             stall,
    input  logic [IDX_W-1:0] rd_idx,
    output entry_t           rd_data,
    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_idx,
    input  entry_t           wr_data
);

    localparam int DEPTH = 1 << IDX_W;

    entry_t           mem [DEPTH];
    logic [DEPTH-1:0] written; // entries touched since reset

    always_ff @(posedge clk) begin
        if (!rstn) begin
            written <= '0;
        end else if (wr_en) begin
            written[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // old data on a same-edge read and write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_data <= RESET_VAL;
        end else if (!stall) begin
            rd_data <= written[rd_idx] ? mem[rd_idx] : RESET_VAL;
        end
    end

endmodule

`default_nettype wire

// File: direction/ghr.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module ghr
    import bp_branch_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                stall,
    input  bp_kind_t            kind_pdc,
    input  logic                taken_pdc,
    bp_update_if.hist           upd,
    output logic [`BP_GH_W-1:0] gh
);

    logic repair;
    logic shift;

    // execute saw a conditional branch go the other way
    assign repair = upd.valid && (upd.ex.kind == direct_jump)
                    && (upd.ex.taken != upd.ex.meta.taken);

    assign shift = !stall && (kind_pdc == direct_jump);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh <= '0;
        end else if (repair) begin
            gh <= {upd.ex.meta.gh[`BP_GH_W-2:0], upd.ex.taken};
        end else if (shift) begin
            gh <= {gh[`BP_GH_W-2:0], taken_pdc}; // speculative
        end
    end

endmodule

`default_nettype wire

// File: direction/dir_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module dir_predictor
    import bp_branch_pkg::*;
    import bp_meta_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall,
    input  logic [`BP_ADDR_W-1:0] pc,
    input  logic [`BP_GH_W-1:0]   gh,
    bp_update_if.dir              upd,
    input  bp_kind_t              kind_pdc,
    output logic                  taken_pdc,
    output bp_meta_t              meta_pdc
);

    ctr2_t                bim_rd;
    ctr2_t                gsh_rd;
    ctr2_t                cho_rd;
    logic [`BP_GH_W-1:0]  gh_q;
    logic                 dir_taken;

    logic [`BP_IDX_W-1:0] bim_idx;
    logic [`BP_IDX_W-1:0] gsh_idx;
    logic [`BP_IDX_W-1:0] bim_idx_ex;
    logic [`BP_IDX_W-1:0] gsh_idx_ex;
    logic                 upd_dir;
    logic                 bim_right;
    logic                 gsh_right;
    logic                 cho_wr;

    function automatic ctr2_t ctr_step(input ctr2_t c, input logic up);
        ctr2_t n;
        n = c;
        if (up && c != 2'b11) begin
            n = c + 2'b01;
        end else if (!up && c != 2'b00) begin
            n = c - 2'b01;
        end
        return n;
    endfunction

    assign bim_idx = pc[`BP_IDX_W-1:0];
    assign gsh_idx = pc[`BP_IDX_W-1:0] ^ gh;

    // snapshot goes out with the counters it indexed
    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh_q <= '0;
        end else if (!stall) begin
            gh_q <= gh;
        end
    end

    // rebuild the read indices from what execute returns
    assign bim_idx_ex = upd.ex.pc[`BP_IDX_W-1:0];
    assign gsh_idx_ex = upd.ex.pc[`BP_IDX_W-1:0] ^ upd.ex.meta.gh;
    assign upd_dir    = upd.valid && (upd.ex.kind == direct_jump);
    assign bim_right  = upd.ex.meta.bim_ctr[1] == upd.ex.taken;
    assign gsh_right  = upd.ex.meta.gsh_ctr[1] == upd.ex.taken;
    assign cho_wr     = upd_dir && (bim_right != gsh_right);

    pred_table #(
        .IDX_W     (`BP_IDX_W),
        .entry_t   (ctr2_t),
        .RESET_VAL (2'b01)
    ) u_bim (
        .clk     (clk),
        .rstn    (rstn),
        .stall   (stall),
        .rd_idx  (bim_idx),
        .rd_data (bim_rd),
        .wr_en   (upd_dir),
        .wr_idx  (bim_idx_ex),
        .wr_data (ctr_step(upd.ex.meta.bim_ctr, upd.ex.taken))
    );

    pred_table #(
        .IDX_W     (`BP_IDX_W),
        .entry_t   (ctr2_t),
        .RESET_VAL (2'b01)
    ) u_gsh (
        .clk     (clk),
        .rstn    (rstn),
        .stall   (stall),
        .rd_idx  (gsh_idx),
        .rd_data (gsh_rd),
        .wr_en   (upd_dir),
        .wr_idx  (gsh_idx_ex),
        .wr_data (ctr_step(upd.ex.meta.gsh_ctr, upd.ex.taken))
    );

    pred_table #(
        .IDX_W     (`BP_IDX_W),
        .entry_t   (ctr2_t),
        .RESET_VAL (2'b01)  // leans bimodal
    ) u_cho (
        .clk     (clk),
        .rstn    (rstn),
        .stall   (stall),
        .rd_idx  (bim_idx),
        .rd_data (cho_rd),
        .wr_en   (cho_wr),
        .wr_idx  (bim_idx_ex),
        .wr_data (ctr_step(upd.ex.meta.cho_ctr, gsh_right))
    );

    assign dir_taken = cho_rd[1] ? gsh_rd[1] : bim_rd[1];

    always_comb begin
        case (kind_pdc)
            direct_jump: taken_pdc = dir_taken;
            not_jump:    taken_pdc = 1'b0;
            default:     taken_pdc = 1'b1; // unconditional kinds
        endcase
    end

    assign meta_pdc = '{
        bim_ctr: bim_rd,
        gsh_ctr: gsh_rd,
        cho_ctr: cho_rd,
        gh:      gh_q,
        taken:   taken_pdc
    };

endmodule

`default_nettype wire

// File: target/npc_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module npc_predictor
    import bp_branch_pkg::*;
    import bp_meta_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall,
    input  logic [`BP_ADDR_W-1:0] pc,
    input  logic [`BP_ADDR_W-1:0] pc_reg,  // pc of the presented prediction
    bp_update_if.tgt              upd,
    input  bp_kind_t              kind_pdc,
    input  logic                  taken_pdc,
    output logic [`BP_ADDR_W-1:0] npc_pdc
);

    localparam int PTR_W = $clog2(`BP_RAS_DEPTH);
    localparam int SP_W  = $clog2(`BP_RAS_DEPTH + 1);

    btb_entry_t            btb_rd;
    btb_entry_t            btb_wr_data;
    logic                  btb_wr;
    logic                  btb_hit;

    logic [`BP_ADDR_W-1:0] ras [`BP_RAS_DEPTH];
    logic [SP_W-1:0]       sp;     // number of valid entries
    logic [PTR_W-1:0]      top_idx;
    logic                  ras_push;
    logic                  ras_pop;
    logic                  ras_full;
    logic                  ras_empty;

    assign btb_wr      = upd.valid && upd.ex.taken && (upd.ex.kind != ret);
    assign btb_wr_data = '{
        valid:  1'b1,
        tag:    upd.ex.pc[`BP_IDX_W +: `BP_TAG_W],
        target: upd.ex.npc
    };

    pred_table #(
        .IDX_W     (`BP_IDX_W),
        .entry_t   (btb_entry_t),
        .RESET_VAL ('0)
    ) u_btb (
        .clk     (clk),
        .rstn    (rstn),
        .stall   (stall),
        .rd_idx  (pc[`BP_IDX_W-1:0]),
        .rd_data (btb_rd),
        .wr_en   (btb_wr),
        .wr_idx  (upd.ex.pc[`BP_IDX_W-1:0]),
        .wr_data (btb_wr_data)
    );

    assign btb_hit = btb_rd.valid && (btb_rd.tag == pc_reg[`BP_IDX_W +: `BP_TAG_W]);

    // ras only moves on resolved calls and returns
    assign ras_push  = upd.valid && (upd.ex.kind == call);
    assign ras_pop   = upd.valid && (upd.ex.kind == ret);
    assign ras_full  = sp == SP_W'(`BP_RAS_DEPTH);
    assign ras_empty = sp == '0;
    assign top_idx   = PTR_W'(sp - SP_W'(1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sp <= '0;
        end else if (ras_push && !ras_full) begin
            sp <= sp + SP_W'(1);
        end else if (ras_pop && !ras_empty) begin
            sp <= sp - SP_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (ras_push && !ras_full) begin
            ras[sp[PTR_W-1:0]] <= upd.ex.ret_pc; // full stack drops the push
        end
    end

    always_comb begin
        if (kind_pdc == ret && !ras_empty) begin
            npc_pdc = ras[top_idx];
        end else if (taken_pdc && btb_hit) begin
            npc_pdc = btb_rd.target;
        end else begin
            npc_pdc = pc_reg + `BP_ADDR_W'(1); // fall through
        end
    end

endmodule

`default_nettype wire

// File: design/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module branch_predictor
    import bp_branch_pkg::*;
    import bp_meta_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall,
    input  logic [`BP_ADDR_W-1:0] pc,
    output logic [`BP_ADDR_W-1:0] npc_pdc,
    output bp_kind_t              kind_pdc,
    output logic                  taken_pdc,
    output bp_meta_t              meta_pdc,
    input  logic                  update_en,
    input  logic [`BP_ADDR_W-1:0] pc_ex,
    input  bp_kind_t              kind_ex,
    input  logic                  taken_ex,
    input  logic [`BP_ADDR_W-1:0] npc_ex,
    input  logic [`BP_ADDR_W-1:0] ret_pc_ex,
    input  bp_meta_t              meta_ex
);

    logic [`BP_ADDR_W-1:0] pc_reg;
    logic [`BP_GH_W-1:0]   gh;

    bp_update_if upd ();

    assign upd.valid = update_en;
    assign upd.ex    = '{
        pc:     pc_ex,
        kind:   kind_ex,
        taken:  taken_ex,
        npc:    npc_ex,
        ret_pc: ret_pc_ex,
        meta:   meta_ex
    };

    // lines up with the registered table reads
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_reg <= `BP_RESET_PC;
        end else if (!stall) begin
            pc_reg <= pc;
        end
    end

    // kind table trained on every resolve
    pred_table #(
        .IDX_W     (`BP_IDX_W),
        .entry_t   (bp_kind_t),
        .RESET_VAL (not_jump)
    ) u_kind (
        .clk     (clk),
        .rstn    (rstn),
        .stall   (stall),
        .rd_idx  (pc[`BP_IDX_W-1:0]),
        .rd_data (kind_pdc),
        .wr_en   (update_en),
        .wr_idx  (pc_ex[`BP_IDX_W-1:0]),
        .wr_data (kind_ex)
    );

    ghr u_ghr (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .kind_pdc  (kind_pdc),
        .taken_pdc (taken_pdc),
        .upd       (upd.hist),
        .gh        (gh)
    );

    dir_predictor u_dir (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .pc        (pc),
        .gh        (gh),
        .upd       (upd.dir),
        .kind_pdc  (kind_pdc),
        .taken_pdc (taken_pdc),
        .meta_pdc  (meta_pdc)
    );

    npc_predictor u_npc (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .pc        (pc),
        .pc_reg    (pc_reg),
        .upd       (upd.tgt),
        .kind_pdc  (kind_pdc),
        .taken_pdc (taken_pdc),
        .npc_pdc   (npc_pdc)
    );

endmodule

`default_nettype wire

// File: verif/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter realtime PERIOD     = 8ns,
    parameter int      RST_CYCLES = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released just after an edge like the other inputs
    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_consts.svh"

module tb_branch_predictor
    import bp_branch_pkg::*;
    import bp_meta_pkg::*;
();

    localparam int RST_TIMEOUT = 50;

    logic                  clk;
    logic                  rstn;
    logic                  stall;
    logic [`BP_ADDR_W-1:0] pc;
    logic [`BP_ADDR_W-1:0] npc_pdc;
    bp_kind_t              kind_pdc;
    logic                  taken_pdc;
    bp_meta_t              meta_pdc;
    logic                  update_en;
    logic [`BP_ADDR_W-1:0] pc_ex;
    bp_kind_t              kind_ex;
    logic                  taken_ex;
    logic [`BP_ADDR_W-1:0] npc_ex;
    logic [`BP_ADDR_W-1:0] ret_pc_ex;
    bp_meta_t              meta_ex;

    // outputs captured by the last predict
    bp_kind_t              kind_q;
    logic                  taken_q;
    logic [`BP_ADDR_W-1:0] npc_q;
    bp_meta_t              meta_q;

    logic [15:0]           lfsr = 16'd26;

    tb_clkgen #(.PERIOD(8ns), .RST_CYCLES(4)) u_clkgen (.clk(clk), .rstn(rstn));

    branch_predictor dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .pc        (pc),
        .npc_pdc   (npc_pdc),
        .kind_pdc  (kind_pdc),
        .taken_pdc (taken_pdc),
        .meta_pdc  (meta_pdc),
        .update_en (update_en),
        .pc_ex     (pc_ex),
        .kind_ex   (kind_ex),
        .taken_ex  (taken_ex),
        .npc_ex    (npc_ex),
        .ret_pc_ex (ret_pc_ex),
        .meta_ex   (meta_ex)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic get_rand(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_val(input string test, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp)
        else fail_stop($sformatf("** Error [%s] expected 0x%0h, actual 0x%0h", test, exp, act));
    endtask

    task automatic sync_drive();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rstn !== 1'b1) begin
            if (n == RST_TIMEOUT) begin
                fail_stop("reset was not released within the expected number of cycles");
            end
            @(posedge clk);
            n++;
        end
        sync_drive();
    endtask

    // one unstalled edge samples the pc and the outputs are read mid-cycle after it
    task automatic predict(input logic [`BP_ADDR_W-1:0] p);
        pc    = p;
        stall = 1'b0;
        sync_drive();
        stall = 1'b1;
        #3;
        kind_q  = kind_pdc;
        taken_q = taken_pdc;
        npc_q   = npc_pdc;
        meta_q  = meta_pdc;
        sync_drive();
    endtask

    task automatic resolve(input logic [`BP_ADDR_W-1:0] rpc, input bp_kind_t rkind,
                           input logic rtaken, input logic [`BP_ADDR_W-1:0] rnpc,
                           input logic [`BP_ADDR_W-1:0] rret, input bp_meta_t rmeta);
        update_en = 1'b1;
        pc_ex     = rpc;
        kind_ex   = rkind;
        taken_ex  = rtaken;
        npc_ex    = rnpc;
        ret_pc_ex = rret;
        meta_ex   = rmeta;
        sync_drive();
        update_en = 1'b0;
    endtask

    initial begin
        logic [31:0]           r;
        logic [`BP_ADDR_W-1:0] p_br;
        logic [`BP_ADDR_W-1:0] tgt;
        logic [`BP_ADDR_W-1:0] p_call;
        logic [`BP_ADDR_W-1:0] call_tgt;
        logic [`BP_ADDR_W-1:0] ret_addr;
        logic [`BP_ADDR_W-1:0] q_ret;
        logic [`BP_GH_W-1:0]   exp_gh;
        logic                  flip;

        stall     = 1'b1;
        pc        = '0;
        update_en = 1'b0;
        pc_ex     = '0;
        kind_ex   = not_jump;
        taken_ex  = 1'b0;
        npc_ex    = '0;
        ret_pc_ex = '0;
        meta_ex   = '0;

        wait_reset_release();
        #3;
        check_val("reset_kind", not_jump, kind_pdc);
        check_val("reset_taken", 1'b0, taken_pdc);
        check_val("reset_npc", `BP_RESET_PC + 30'd1, npc_pdc);
        sync_drive();

        // untrained pcs fall through
        for (int i = 0; i < 4; i++) begin
            get_rand(30, r);
            predict(r[29:0]);
            check_val("untrained_kind", not_jump, kind_q);
            check_val("untrained_taken", 1'b0, taken_q);
            check_val("untrained_npc", 30'(r[29:0] + 30'd1), npc_q);
        end

        // distinct low bytes keep the untagged tables apart
        get_rand(22, r);
        p_br = {r[21:0], 8'h21};
        get_rand(30, r);
        tgt = r[29:0];
        for (int i = 0; i < 3; i++) begin
            predict(p_br);
            resolve(p_br, direct_jump, 1'b1, tgt, '0, meta_q);
        end
        predict(p_br);
        check_val("direct_taken_kind", direct_jump, kind_q);
        check_val("direct_taken", 1'b1, taken_q);
        check_val("direct_taken_npc", tgt, npc_q);
        for (int i = 0; i < 3; i++) begin
            predict(p_br);
            resolve(p_br, direct_jump, 1'b0, p_br + 30'd1, '0, meta_q);
        end
        predict(p_br);
        check_val("direct_not_taken", 1'b0, taken_q);
        check_val("direct_not_taken_npc", p_br + 30'd1, npc_q);

        get_rand(22, r);
        p_call = {r[21:0], 8'h42};
        get_rand(22, r);
        q_ret = {r[21:0], 8'h63};
        get_rand(30, r);
        call_tgt = r[29:0];
        get_rand(30, r);
        ret_addr = r[29:0];
        // two calls deep so training the ret leaves one entry
        for (int i = 0; i < 2; i++) begin
            predict(p_call);
            resolve(p_call, call, 1'b1, call_tgt, ret_addr, meta_q);
        end
        predict(q_ret);
        resolve(q_ret, ret, 1'b1, ret_addr, '0, meta_q);
        predict(q_ret);
        check_val("ras_kind", ret, kind_q);
        check_val("ras_npc", ret_addr, npc_q);
        resolve(q_ret, ret, 1'b1, ret_addr, '0, meta_q);
        predict(q_ret);
        check_val("ras_empty_npc", q_ret + 30'd1, npc_q);

        predict(p_call);
        check_val("call_kind", call, kind_q);
        check_val("call_taken", 1'b1, taken_q);
        check_val("call_npc", call_tgt, npc_q);
        for (int i = 0; i < 5; i++) begin
            get_rand(30, r);
            pc = r[29:0];
            @(posedge clk);
            #3;
            check_val("stall_hold_kind", call, kind_pdc);
            check_val("stall_hold_taken", 1'b1, taken_pdc);
            check_val("stall_hold_npc", call_tgt, npc_pdc);
            check_val("stall_hold_meta", meta_q, meta_pdc);
            sync_drive();
        end

        predict(p_br);
        flip   = ~meta_q.taken;
        exp_gh = (meta_q.gh << 1) | `BP_GH_W'(flip);
        resolve(p_br, direct_jump, flip, flip ? tgt : p_br + 30'd1, '0, meta_q);
        predict(p_call);
        check_val("gh_repair", exp_gh, meta_q.gh);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: branch_predictor.f
+incdir+common
common/bp_meta_pkg.sv
common/bp_branch_pkg.sv
common/bp_update_if.sv
design/pred_table.sv
direction/ghr.sv
direction/dir_predictor.sv
target/npc_predictor.sv
design/branch_predictor.sv
verif/tb_clkgen.sv
verif/tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - include_dirs:
      - common
    files:
      - common/bp_meta_pkg.sv
      - common/bp_branch_pkg.sv
      - common/bp_update_if.sv
      - design/pred_table.sv
      - direction/ghr.sv
      - direction/dir_predictor.sv
      - target/npc_predictor.sv
      - design/branch_predictor.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_clkgen.sv
      - verif/tb_branch_predictor.sv
